// File: src/cnt_pkg.sv
// Pulse counter shared definitions
package cnt_pkg;

   localparam int NUM_CH    = 2;
   localparam int NUM_IN    = 8;                 // Inputs seen by the trigger
   localparam int BUS_DW    = 32;
   localparam int BIN_AW    = 12;
   localparam int BIN_DW    = 18;
   localparam int BIN_DEPTH = 2 ** BIN_AW;
   localparam int NBINS_W   = BIN_AW + 1;        // Must hold BIN_DEPTH itself
   localparam int REPS_W    = 16;
   localparam int TRIG_W    = 2 * NUM_IN + 1;    // Mask, invert, polarity

   typedef logic [BUS_DW-1:0]  bus_word_t;
   typedef logic [BIN_AW-1:0]  bin_addr_t;
   typedef logic [BIN_DW-1:0]  bin_data_t;
   typedef logic [NBINS_W-1:0] nbins_t;
   typedef logic [REPS_W-1:0]  reps_t;
   typedef logic [TRIG_W-1:0]  trig_cfg_t;

   // Codes are visible to software through the status register
   typedef enum logic [2:0] {
      st_idle          = 3'd0,
      st_imm_count     = 3'd2,
      st_trig_wait     = 3'd3,
      st_trig_store    = 3'd4,
      st_trig_predelay = 3'd5,
      st_trig_prestore = 3'd6,
      st_trig_count    = 3'd7
   } state_t;

   typedef enum logic [2:0] {
      cmd_none            = 3'd0,
      cmd_goto_idle       = 3'd1,
      cmd_clear           = 3'd2,
      cmd_count_immediate = 3'd3,
      cmd_count_triggered = 3'd4
   } cmd_t;

   // Register map
   localparam bus_word_t REG_CMD      = 32'h0000_0000;
   localparam bus_word_t REG_TIMEOUT  = 32'h0000_0004;
   localparam bus_word_t REG_LAST0    = 32'h0000_0008;
   localparam bus_word_t REG_LAST1    = 32'h0000_000C;
   localparam bus_word_t REG_NBINS    = 32'h0000_0010;
   localparam bus_word_t REG_REPS     = 32'h0000_0014;
   localparam bus_word_t REG_PREDELAY = 32'h0000_0018;
   localparam bus_word_t REG_TRIG     = 32'h0000_001C;
   localparam bus_word_t REG_BIN_IDX  = 32'h0000_0020;
   localparam bus_word_t REG_REP_IDX  = 32'h0000_0024;

   // Bin RAM window
   localparam bus_word_t RAM_BASE         = 32'h0001_0000;
   localparam int        RAM_CH_BIT       = 14;
   localparam int        RAM_UNMAPPED_BIT = 15;

   localparam bus_word_t TIMEOUT_DEFAULT  = 32'd125;
   localparam nbins_t    NBINS_DEFAULT    = nbins_t'(BIN_DEPTH);
   localparam reps_t     REPS_DEFAULT     = '0;
   localparam bus_word_t PREDELAY_DEFAULT = '0;
   localparam trig_cfg_t TRIG_DEFAULT     = '0;

endpackage

// File: src/cnt_cfg_if.sv
// Configuration and status link
`timescale 1ns/100ps

interface cnt_cfg_if import cnt_pkg::*; ();

   // Register block to state machine
   bus_word_t              timeout;
   bus_word_t              predelay;
   nbins_t                 nbins;
   reps_t                  reps;
   trig_cfg_t              trig;
   cmd_t                   cmd;
   logic                   cmd_valid;     // One pulse per command write

   // State machine back to register block
   bin_addr_t              bin_idx;
   reps_t                  rep_idx;
   state_t                 state;
   bus_word_t [NUM_CH-1:0] last_count;

   modport regs (
      output timeout, predelay, nbins, reps, trig, cmd, cmd_valid,
      input  bin_idx, rep_idx, state, last_count
   );

   modport fsm (
      input  timeout, predelay, nbins, reps, trig, cmd, cmd_valid,
      output bin_idx, rep_idx, state, last_count
   );

endinterface

// File: src/interval_timer.sv
// Predelay and timeout down-counter
`timescale 1ns/100ps

module interval_timer import cnt_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rstn,
   input  logic      i_load,
   input  bus_word_t i_value,
   output logic      o_expired
);

   bus_word_t remaining;

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         remaining <= '0;
      end else if (i_load) begin
         remaining <= i_value;
      end else if (remaining != '0) begin
         remaining <= remaining - 1'b1;   // Holds at zero
      end
   end

   // Level, stays high until the next load
   assign o_expired = (remaining == '0);

endmodule

// File: src/pulse_counter.sv
// Rising edge counters
`timescale 1ns/100ps

module pulse_counter import cnt_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_rstn,
   input  logic [NUM_CH-1:0]      i_signals,
   input  logic                   i_clear,
   input  logic                   i_enable,
   output bus_word_t [NUM_CH-1:0] o_counts
);

   logic [NUM_CH-1:0] sig_q;
   logic [NUM_CH-1:0] sig_qq;

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         sig_q    <= '0;
         sig_qq   <= '0;
         o_counts <= '0;
      end else begin
         sig_q  <= i_signals;   // Sampled input
         sig_qq <= sig_q;
         for (int ch = 0; ch < NUM_CH; ch++) begin
            if (i_clear)
               o_counts[ch] <= '0;
            else if (i_enable && sig_q[ch] && !sig_qq[ch])
               o_counts[ch] <= o_counts[ch] + 1'b1;
         end
      end
   end

endmodule

// File: src/bin_memory.sv
// Histogram bin RAM
`timescale 1ns/100ps

module bin_memory import cnt_pkg::*; (
   input  logic      i_clk,

   // Accumulate side, state machine
   input  bin_addr_t i_acc_addr,
   input  logic      i_acc_we,
   input  bin_data_t i_acc_wdata,
   output bin_data_t o_acc_rdata,

   // Software side
   input  bin_addr_t i_bus_addr,
   input  logic      i_bus_we,
   input  bin_data_t i_bus_wdata,
   output bin_data_t o_bus_rdata
);

   bin_data_t mem [BIN_DEPTH];

   // Both ports read old data on a same-address write
   always_ff @(posedge i_clk) begin
      if (i_acc_we)
         mem[i_acc_addr] <= i_acc_wdata;
      if (i_bus_we)
         mem[i_bus_addr] <= i_bus_wdata;   // Bus side wins a collision
      o_acc_rdata <= mem[i_acc_addr];
      o_bus_rdata <= mem[i_bus_addr];
   end

endmodule

// File: src/count_fsm.sv
// Measurement state machine
`timescale 1ns/100ps

module count_fsm import cnt_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_rstn,
   input  logic [NUM_IN-1:0]      i_inputs,
   cnt_cfg_if.fsm                 cfg,
   output logic                   o_tmr_load,
   output bus_word_t              o_tmr_value,
   input  logic                   i_tmr_expired,
   output logic                   o_cnt_clear,
   output logic                   o_cnt_enable,
   input  bus_word_t [NUM_CH-1:0] i_counts,
   output bin_addr_t              o_bin_addr,
   output logic                   o_bin_we,
   output bin_data_t [NUM_CH-1:0] o_bin_wdata,
   input  bin_data_t [NUM_CH-1:0] i_bin_rdata
);

   state_t                 state;
   state_t                 state_d;
   bin_addr_t              bin_idx;
   reps_t                  rep_idx;
   bus_word_t [NUM_CH-1:0] last_count;
   logic                   trig_hit;
   logic                   bin_wrap;
   logic                   latch_counts;
   logic                   advance;
   logic                   clear_idx;

   // Any selected input active after inversion, compared with the polarity bit
   assign trig_hit = (|((i_inputs ^ cfg.trig[2*NUM_IN-1:NUM_IN]) & cfg.trig[NUM_IN-1:0]))
                     == cfg.trig[2*NUM_IN];

   assign bin_wrap = ({1'b0, bin_idx} == cfg.nbins - 1'b1);

   always_comb begin
      state_d      = state;
      o_tmr_load   = 1'b0;
      o_tmr_value  = cfg.timeout;
      latch_counts = 1'b0;
      advance      = 1'b0;
      clear_idx    = 1'b0;
      if (cfg.cmd_valid && cfg.cmd != cmd_none) begin
         // Commands override whatever is running
         case (cfg.cmd)
            cmd_goto_idle: state_d = st_idle;
            cmd_clear: begin
               state_d   = st_idle;
               clear_idx = 1'b1;
            end
            cmd_count_immediate: begin
               state_d    = st_imm_count;
               o_tmr_load = 1'b1;
            end
            cmd_count_triggered: state_d = st_trig_wait;
            default: state_d = state;
         endcase
      end else begin
         case (state)
            st_imm_count: begin
               if (i_tmr_expired) begin
                  latch_counts = 1'b1;
                  state_d      = st_idle;
               end
            end
            st_trig_wait: begin
               if (trig_hit) begin
                  o_tmr_load = 1'b1;
                  if (cfg.predelay != '0) begin
                     o_tmr_value = cfg.predelay;
                     state_d     = st_trig_predelay;
                  end else begin
                     state_d = st_trig_count;   // No predelay, open window now
                  end
               end
            end
            st_trig_predelay: begin
               if (i_tmr_expired) begin
                  o_tmr_load = 1'b1;
                  state_d    = st_trig_count;
               end
            end
            st_trig_count: begin
               if (i_tmr_expired) begin
                  latch_counts = 1'b1;
                  state_d      = st_trig_prestore;
               end
            end
            st_trig_prestore: state_d = st_trig_store;   // RAM write happens here
            st_trig_store: begin
               advance = 1'b1;
               state_d = st_trig_wait;
            end
            default: state_d = st_idle;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         state      <= st_idle;
         bin_idx    <= '0;
         rep_idx    <= '0;
         last_count <= '0;
      end else begin
         state <= state_d;
         if (clear_idx) begin
            bin_idx    <= '0;
            rep_idx    <= '0;
            last_count <= '0;
         end else begin
            if (latch_counts)
               last_count <= i_counts;
            if (advance) begin
               // Bin moves on once it has seen reps + 1 windows
               if (rep_idx == cfg.reps) begin
                  rep_idx <= '0;
                  bin_idx <= bin_wrap ? '0 : bin_idx + 1'b1;
               end else begin
                  rep_idx <= rep_idx + 1'b1;
               end
            end
         end
      end
   end

   assign o_cnt_enable = (state == st_imm_count) || (state == st_trig_count);
   assign o_cnt_clear  = o_tmr_load || !o_cnt_enable;   // Fresh start on every window

   assign o_bin_addr = bin_idx;
   assign o_bin_we   = (state == st_trig_prestore);

   for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_acc
      assign o_bin_wdata[ch] = i_bin_rdata[ch] + last_count[ch][BIN_DW-1:0];
   end

   assign cfg.state      = state;
   assign cfg.bin_idx    = bin_idx;
   assign cfg.rep_idx    = rep_idx;
   assign cfg.last_count = last_count;

endmodule

// File: src/bus_regs.sv
// System bus register block
`timescale 1ns/100ps

module bus_regs import cnt_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_rstn,
   input  bus_word_t              i_sys_addr,
   input  bus_word_t              i_sys_wdata,
   input  logic                   i_sys_wen,
   input  logic                   i_sys_ren,
   output bus_word_t              o_sys_rdata,
   output logic                   o_sys_ack,
   cnt_cfg_if.regs                cfg,
   output bin_addr_t              o_ram_addr,
   output logic                   o_ram_ch,
   output logic                   o_ram_we,
   output bin_data_t              o_ram_wdata,
   input  bin_data_t [NUM_CH-1:0] i_ram_rdata
);

   logic      sys_en;
   logic      ram_sel;
   logic      ram_rd;
   logic      ram_rd_pend;
   logic      ram_rd_done;
   cmd_t      cmd_dec;
   bus_word_t reg_rdata;
   bus_word_t rdata_q;
   bus_word_t timeout_q;
   bus_word_t predelay_q;
   nbins_t    nbins_q;
   reps_t     reps_q;
   trig_cfg_t trig_q;
   cmd_t      cmd_q;
   logic      cmd_valid_q;

   assign sys_en  = i_sys_wen || i_sys_ren;
   assign ram_sel = (i_sys_addr[31:16] == RAM_BASE[31:16]) && !i_sys_addr[RAM_UNMAPPED_BIT];
   assign ram_rd  = ram_sel && i_sys_ren && !i_sys_wen;

   // Unknown command codes do nothing
   always_comb begin
      if (i_sys_wdata <= bus_word_t'(cmd_count_triggered))
         cmd_dec = cmd_t'(i_sys_wdata[2:0]);
      else
         cmd_dec = cmd_none;
   end

   always_comb begin
      case (i_sys_addr)
         REG_CMD:      reg_rdata = bus_word_t'(cfg.state);   // Status readback
         REG_TIMEOUT:  reg_rdata = timeout_q;
         REG_LAST0:    reg_rdata = cfg.last_count[0];
         REG_LAST1:    reg_rdata = cfg.last_count[1];
         REG_NBINS:    reg_rdata = bus_word_t'(nbins_q);
         REG_REPS:     reg_rdata = bus_word_t'(reps_q);
         REG_PREDELAY: reg_rdata = predelay_q;
         REG_TRIG:     reg_rdata = bus_word_t'(trig_q);
         REG_BIN_IDX:  reg_rdata = bus_word_t'(cfg.bin_idx);
         REG_REP_IDX:  reg_rdata = bus_word_t'(cfg.rep_idx);
         default:      reg_rdata = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         timeout_q   <= TIMEOUT_DEFAULT;
         predelay_q  <= PREDELAY_DEFAULT;
         nbins_q     <= NBINS_DEFAULT;
         reps_q      <= REPS_DEFAULT;
         trig_q      <= TRIG_DEFAULT;
         cmd_q       <= cmd_none;
         cmd_valid_q <= 1'b0;
         o_ram_we    <= 1'b0;
         ram_rd_pend <= 1'b0;
         ram_rd_done <= 1'b0;
         o_sys_ack   <= 1'b0;
      end else begin
         cmd_valid_q <= 1'b0;
         o_ram_we    <= 1'b0;
         ram_rd_pend <= ram_rd;
         ram_rd_done <= ram_rd_pend;
         // RAM reads wait one extra cycle for the registered RAM output
         o_sys_ack   <= (sys_en && !ram_rd) || ram_rd_pend;
         if (i_sys_wen) begin
            if (ram_sel) begin
               o_ram_we <= 1'b1;
            end else begin
               case (i_sys_addr)
                  REG_CMD: begin
                     cmd_q       <= cmd_dec;
                     cmd_valid_q <= 1'b1;
                  end
                  REG_TIMEOUT:  timeout_q  <= i_sys_wdata;
                  REG_NBINS:    nbins_q    <= i_sys_wdata[NBINS_W-1:0];
                  REG_REPS:     reps_q     <= i_sys_wdata[REPS_W-1:0];
                  REG_PREDELAY: predelay_q <= i_sys_wdata;
                  REG_TRIG:     trig_q     <= i_sys_wdata[TRIG_W-1:0];
                  default:      cmd_valid_q <= 1'b0;   // Read-only or unmapped
               endcase
            end
         end
      end
   end

   // Data path, captured on every strobe
   always_ff @(posedge i_clk) begin
      if (sys_en) begin
         rdata_q <= reg_rdata;
         if (ram_sel) begin
            o_ram_addr  <= i_sys_addr[2 +: BIN_AW];
            o_ram_ch    <= i_sys_addr[RAM_CH_BIT];
            o_ram_wdata <= i_sys_wdata[BIN_DW-1:0];
         end
      end
   end

   assign o_sys_rdata = ram_rd_done ? bus_word_t'(i_ram_rdata[o_ram_ch]) : rdata_q;

   assign cfg.timeout   = timeout_q;
   assign cfg.predelay  = predelay_q;
   assign cfg.nbins     = nbins_q;
   assign cfg.reps      = reps_q;
   assign cfg.trig      = trig_q;
   assign cfg.cmd       = cmd_q;
   assign cfg.cmd_valid = cmd_valid_q;

endmodule

// File: src/counter_top.sv
// Two channel pulse counter
`timescale 1ns/100ps

module counter_top import cnt_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rstn,
   input  logic [NUM_IN-1:0] i_inputs,
   input  bus_word_t         i_sys_addr,
   input  bus_word_t         i_sys_wdata,
   input  logic              i_sys_wen,
   input  logic              i_sys_ren,
   output bus_word_t         o_sys_rdata,
   output logic              o_sys_ack
);

   logic                   tmr_load;
   bus_word_t              tmr_value;
   logic                   tmr_expired;
   logic                   cnt_clear;
   logic                   cnt_enable;
   bus_word_t [NUM_CH-1:0] counts;
   bin_addr_t              bin_addr;
   logic                   bin_we;
   bin_data_t [NUM_CH-1:0] bin_wdata;
   bin_data_t [NUM_CH-1:0] bin_rdata;
   bin_addr_t              ram_addr;
   logic                   ram_ch;
   logic                   ram_we;
   bin_data_t              ram_wdata;
   bin_data_t [NUM_CH-1:0] ram_rdata;

   cnt_cfg_if cfg ();

   bus_regs u_bus_regs (
      .i_clk       (i_clk),
      .i_rstn      (i_rstn),
      .i_sys_addr  (i_sys_addr),
      .i_sys_wdata (i_sys_wdata),
      .i_sys_wen   (i_sys_wen),
      .i_sys_ren   (i_sys_ren),
      .o_sys_rdata (o_sys_rdata),
      .o_sys_ack   (o_sys_ack),
      .cfg         (cfg.regs),
      .o_ram_addr  (ram_addr),
      .o_ram_ch    (ram_ch),
      .o_ram_we    (ram_we),
      .o_ram_wdata (ram_wdata),
      .i_ram_rdata (ram_rdata)
   );

   count_fsm u_count_fsm (
      .i_clk         (i_clk),
      .i_rstn        (i_rstn),
      .i_inputs      (i_inputs),
      .cfg           (cfg.fsm),
      .o_tmr_load    (tmr_load),
      .o_tmr_value   (tmr_value),
      .i_tmr_expired (tmr_expired),
      .o_cnt_clear   (cnt_clear),
      .o_cnt_enable  (cnt_enable),
      .i_counts      (counts),
      .o_bin_addr    (bin_addr),
      .o_bin_we      (bin_we),
      .o_bin_wdata   (bin_wdata),
      .i_bin_rdata   (bin_rdata)
   );

   interval_timer u_timer (
      .i_clk     (i_clk),
      .i_rstn    (i_rstn),
      .i_load    (tmr_load),
      .i_value   (tmr_value),
      .o_expired (tmr_expired)
   );

   pulse_counter u_pulse_counter (
      .i_clk     (i_clk),
      .i_rstn    (i_rstn),
      .i_signals (i_inputs[NUM_CH-1:0]),   // Low inputs are the counted channels
      .i_clear   (cnt_clear),
      .i_enable  (cnt_enable),
      .o_counts  (counts)
   );

   for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_mem
      bin_memory u_bin_memory (
         .i_clk       (i_clk),
         .i_acc_addr  (bin_addr),
         .i_acc_we    (bin_we),
         .i_acc_wdata (bin_wdata[ch]),
         .o_acc_rdata (bin_rdata[ch]),
         .i_bus_addr  (ram_addr),
         .i_bus_we    (ram_we && (int'(ram_ch) == ch)),
         .i_bus_wdata (ram_wdata),
         .o_bus_rdata (ram_rdata[ch])
      );
   end

endmodule

// File: verif/counter_tb_sva.sv
// Bus and state machine assertions
`timescale 1ns/100ps

module counter_tb_sva import cnt_pkg::*; (
   input logic   i_clk,
   input logic   i_rstn,
   input logic   i_pulse,       // Strobe that never lasts two cycles
   input logic   i_cmd_valid,
   input state_t i_state
);

   pulse_single: assert property (@(posedge i_clk) disable iff (!i_rstn)
      i_pulse |=> !i_pulse)
      else $error("Single-cycle strobe high for two cycles");

   cmd_single: assert property (@(posedge i_clk) disable iff (!i_rstn)
      i_cmd_valid |=> !i_cmd_valid)
      else $error("Command strobe longer than one cycle");

   idle_after_reset: assert property (@(posedge i_clk)
      $rose(i_rstn) |-> (i_state == st_idle))
      else $error("State machine not idle after reset release");

endmodule

// Accumulate write enable, one bin update per window
bind count_fsm counter_tb_sva u_fsm_sva (
   .i_clk       (i_clk),
   .i_rstn      (i_rstn),
   .i_pulse     (o_bin_we),
   .i_cmd_valid (cfg.cmd_valid),
   .i_state     (state)
);

// Bus acknowledge and command strobe at the source
bind bus_regs counter_tb_sva u_regs_sva (
   .i_clk       (i_clk),
   .i_rstn      (i_rstn),
   .i_pulse     (o_sys_ack),
   .i_cmd_valid (cmd_valid_q),
   .i_state     (cfg.state)
);

// File: verif/counter_tb.sv
// Pulse counter testbench
`timescale 1ns/100ps

module counter_tb import cnt_pkg::*; ();

   localparam int        BUS_WAIT_MAX  = 8;      // Cycles until an acknowledge
   localparam int        POLL_MAX      = 400;    // Status reads per wait
   localparam int        DRAIN_MAX     = 10;
   localparam bus_word_t TEST_TIMEOUT  = 32'd300;
   localparam bus_word_t TEST_PREDELAY = 32'd20;
   localparam int        TEST_BINS     = 3;
   localparam int        TEST_REPS     = 1;
   localparam int        TRIG_WINDOWS  = 7;      // Enough to wrap the bin index once
   localparam bus_word_t TRIG_INPUT2   = 32'h0001_0004;   // Mask bit 2, polarity high

   typedef enum {chk_word, chk_bin, chk_state} check_kind_t;

   typedef struct {
      string       label;
      check_kind_t kind;
      bus_word_t   exp_val;
      bus_word_t   act_val;
   } check_t;

   logic        clk = 1'b0;
   logic        rstn;
   logic [7:0]  inputs;
   bus_word_t   sys_addr;
   bus_word_t   sys_wdata;
   logic        sys_wen;
   logic        sys_ren;
   bus_word_t   sys_rdata;
   logic        sys_ack;

   check_t      checks [$];                       // Filled by stimulus, drained below
   int          seed = 32'h54f2_0972;
   int          burst [NUM_CH];                   // Pulses per channel in the next window
   bin_data_t   model_bins [NUM_CH][TEST_BINS];
   int          model_bin;
   int          model_rep;

   always #50 clk = ~clk;

   counter_top uut (
      .i_clk       (clk),
      .i_rstn      (rstn),
      .i_inputs    (inputs),
      .i_sys_addr  (sys_addr),
      .i_sys_wdata (sys_wdata),
      .i_sys_wen   (sys_wen),
      .i_sys_ren   (sys_ren),
      .o_sys_rdata (sys_rdata),
      .o_sys_ack   (sys_ack)
   );

   task automatic abort_run(string reason);
      $display("%s", reason);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic compare_word(string label, bus_word_t expected, bus_word_t actual);
      if (actual !== expected)
         abort_run($sformatf("Fail %s: expected %0h, actual %0h", label, expected, actual));
   endtask

   task automatic compare_bin(string label, bin_data_t expected, bin_data_t actual);
      if (actual !== expected)
         abort_run($sformatf("Fail %s: expected %0h, actual %0h", label, expected, actual));
   endtask

   task automatic compare_state(string label, state_t expected, state_t actual);
      if (actual !== expected)
         abort_run($sformatf("Fail %s: expected %s, actual %0d", label, expected.name(),
                             actual));
   endtask

   // New bin content is the old one plus the count, modulo 2^18
   function automatic bin_data_t bin_update(bin_data_t old_val, bus_word_t count);
      logic [BIN_DW:0] sum;
      sum = {1'b0, old_val} + {1'b0, count[BIN_DW-1:0]};
      return sum[BIN_DW-1:0];
   endfunction

   function automatic bus_word_t ram_addr(int ch, int bin);
      return RAM_BASE | (bus_word_t'(ch) << RAM_CH_BIT) | (bus_word_t'(bin) << 2);
   endfunction

   // Expected histogram after one triggered window
   task automatic model_window();
      for (int ch = 0; ch < NUM_CH; ch++)
         model_bins[ch][model_bin] = bin_update(model_bins[ch][model_bin],
                                                bus_word_t'(burst[ch]));
      if (model_rep == TEST_REPS) begin
         model_rep = 0;
         model_bin = (model_bin + 1 == TEST_BINS) ? 0 : model_bin + 1;   // Wrap
      end else begin
         model_rep++;
      end
   endtask

   function automatic void expect_value(string label, check_kind_t kind, bus_word_t exp_val,
                                        bus_word_t act_val);
      check_t c;
      c.label   = label;
      c.kind    = kind;
      c.exp_val = exp_val;
      c.act_val = act_val;
      checks.push_back(c);
   endfunction

   // One strobe, then wait for the acknowledge
   task automatic bus_access(input bus_word_t addr, input bus_word_t wdata, input logic write,
                             output bus_word_t rdata);
      int waited;
      waited = 0;
      @(negedge clk);
      sys_addr  = addr;
      sys_wdata = wdata;
      sys_wen   = write;
      sys_ren   = !write;
      do begin
         @(negedge clk);
         sys_wen = 1'b0;
         sys_ren = 1'b0;
         waited++;
         if (waited > BUS_WAIT_MAX)
            abort_run($sformatf("No bus acknowledge for address %h", addr));
      end while (!sys_ack);
      rdata = sys_rdata;
   endtask

   task automatic bus_write(bus_word_t addr, bus_word_t wdata);
      bus_word_t unused_rdata;
      bus_access(addr, wdata, 1'b1, unused_rdata);
   endtask

   task automatic bus_read(input bus_word_t addr, output bus_word_t rdata);
      bus_access(addr, '0, 1'b0, rdata);
   endtask

   task automatic check_register(string label, bus_word_t addr, bus_word_t expected);
      bus_word_t rd;
      bus_read(addr, rd);
      expect_value(label, chk_word, expected, rd);
   endtask

   task automatic check_status(string label, state_t expected);
      bus_word_t rd;
      bus_read(REG_CMD, rd);
      expect_value(label, chk_state, bus_word_t'(expected), rd);
   endtask

   task automatic check_bin_ram(string label, int ch, int bin, bin_data_t expected);
      bus_word_t rd;
      bus_read(ram_addr(ch, bin), rd);
      expect_value(label, chk_bin, bus_word_t'(expected), rd);
   endtask

   task automatic write_readback(string label, bus_word_t addr, bus_word_t wdata,
                                 bus_word_t expected);
      bus_write(addr, wdata);
      check_register(label, addr, expected);
   endtask

   task automatic wait_status(state_t target, string what);
      bus_word_t rd;
      int        polls;
      polls = 0;
      bus_read(REG_CMD, rd);
      while (rd[2:0] != target) begin
         polls++;
         if (polls > POLL_MAX)
            abort_run($sformatf("Status never reached %s while %s", target.name(), what));
         bus_read(REG_CMD, rd);
      end
   endtask

   task automatic pick_burst();
      for (int ch = 0; ch < NUM_CH; ch++)
         burst[ch] = int'($unsigned($random(seed)) % 32'd60);
   endtask

   // One cycle high, one low, all channels in step
   task automatic drive_burst();
      int longest;
      longest = 0;
      for (int ch = 0; ch < NUM_CH; ch++)
         if (burst[ch] > longest)
            longest = burst[ch];
      for (int i = 0; i < longest; i++) begin
         @(negedge clk);
         for (int ch = 0; ch < NUM_CH; ch++)
            inputs[ch] = (i < burst[ch]);
         @(negedge clk);
         inputs[NUM_CH-1:0] = '0;
      end
   endtask

   // Comparing process
   always @(negedge clk) begin
      check_t c;
      while (checks.size() > 0) begin
         c = checks.pop_front();
         case (c.kind)
            chk_word: compare_word(c.label, c.exp_val, c.act_val);
            chk_bin:  compare_bin(c.label, bin_data_t'(c.exp_val), bin_data_t'(c.act_val));
            default:  compare_state(c.label, state_t'(c.exp_val[2:0]), state_t'(c.act_val[2:0]));
         endcase
      end
   end

   initial begin
      int        written;
      int        drain;
      bin_addr_t rand_bin;
      bin_data_t rand_word;
      rstn      = 1'b0;
      inputs    = '0;
      sys_addr  = '0;
      sys_wdata = '0;
      sys_wen   = 1'b0;
      sys_ren   = 1'b0;
      repeat (3) @(negedge clk);
      rstn = 1'b1;

      // Reset defaults
      check_status("reset status", st_idle);
      check_register("reset timeout", REG_TIMEOUT, TIMEOUT_DEFAULT);
      check_register("reset last0", REG_LAST0, '0);
      check_register("reset last1", REG_LAST1, '0);
      check_register("reset nbins", REG_NBINS, bus_word_t'(NBINS_DEFAULT));
      check_register("reset reps", REG_REPS, bus_word_t'(REPS_DEFAULT));
      check_register("reset predelay", REG_PREDELAY, PREDELAY_DEFAULT);
      check_register("reset trig", REG_TRIG, bus_word_t'(TRIG_DEFAULT));
      check_register("reset bin index", REG_BIN_IDX, '0);
      check_register("reset rep index", REG_REP_IDX, '0);
      check_register("unmapped register", 32'h0000_0028, '0);
      check_register("unmapped ram", RAM_BASE | 32'h0000_8000, '0);   // Bit 15 set

      // Configuration readback, truncated to field widths
      write_readback("cfg timeout", REG_TIMEOUT, 32'hDEAD_BEEF, 32'hDEAD_BEEF);
      write_readback("cfg predelay", REG_PREDELAY, 32'h1234_5678, 32'h1234_5678);
      write_readback("cfg nbins", REG_NBINS, 32'hFFFF_F00A,
                     bus_word_t'(nbins_t'(32'hFFFF_F00A)));
      write_readback("cfg reps", REG_REPS, 32'hABCD_1234, bus_word_t'(reps_t'(32'hABCD_1234)));
      write_readback("cfg trig", REG_TRIG, 32'hFFFF_FFFF, bus_word_t'(trig_cfg_t'(32'hFFFF_FFFF)));

      // Immediate mode
      bus_write(REG_TIMEOUT, TEST_TIMEOUT);
      pick_burst();
      bus_write(REG_CMD, bus_word_t'(cmd_count_immediate));
      repeat (10) @(negedge clk);
      drive_burst();
      wait_status(st_idle, "counting immediately");
      check_register("imm last0", REG_LAST0, bus_word_t'(burst[0]));
      check_register("imm last1", REG_LAST1, bus_word_t'(burst[1]));

      // Triggered mode on input 2
      for (int b = 0; b < TEST_BINS; b++) begin
         for (int ch = 0; ch < NUM_CH; ch++) begin
            bus_write(ram_addr(ch, b), '0);
            model_bins[ch][b] = '0;
         end
      end
      bus_write(REG_PREDELAY, TEST_PREDELAY);
      bus_write(REG_NBINS, bus_word_t'(TEST_BINS));
      bus_write(REG_REPS, bus_word_t'(TEST_REPS));
      bus_write(REG_TRIG, TRIG_INPUT2);
      model_bin = 0;
      model_rep = 0;
      bus_write(REG_CMD, bus_word_t'(cmd_count_triggered));
      repeat (4) check_status("trig without input", st_trig_wait);
      for (int w = 0; w < TRIG_WINDOWS; w++) begin
         written = model_bin;
         pick_burst();
         @(negedge clk);
         inputs[2] = 1'b1;
         @(negedge clk);
         inputs[2] = 1'b0;
         wait_status(st_trig_count, "waiting for the window to open");
         repeat (10) @(negedge clk);
         drive_burst();
         wait_status(st_trig_wait, "waiting for the window to end");
         model_window();
         check_register("trig last0", REG_LAST0, bus_word_t'(burst[0]));
         check_register("trig last1", REG_LAST1, bus_word_t'(burst[1]));
         for (int ch = 0; ch < NUM_CH; ch++)
            check_bin_ram($sformatf("window %0d bin ch%0d", w, ch), ch, written,
                          model_bins[ch][written]);
         check_register("trig bin index", REG_BIN_IDX, bus_word_t'(model_bin));
         check_register("trig rep index", REG_REP_IDX, bus_word_t'(model_rep));
      end

      // Clear keeps the RAM
      bus_write(REG_CMD, bus_word_t'(cmd_clear));
      check_status("clear status", st_idle);
      check_register("clear bin index", REG_BIN_IDX, '0);
      check_register("clear rep index", REG_REP_IDX, '0);
      check_register("clear last0", REG_LAST0, '0);
      check_register("clear last1", REG_LAST1, '0);
      for (int b = 0; b < TEST_BINS; b++)
         for (int ch = 0; ch < NUM_CH; ch++)
            check_bin_ram($sformatf("kept bin %0d ch%0d", b, ch), ch, b, model_bins[ch][b]);
      bus_write(REG_CMD, bus_word_t'(cmd_count_immediate));
      check_status("running before idle", st_imm_count);
      bus_write(REG_CMD, bus_word_t'(cmd_goto_idle));
      check_status("goto idle", st_idle);

      // Random RAM words
      for (int ch = 0; ch < NUM_CH; ch++) begin
         rand_bin  = bin_addr_t'($random(seed));
         rand_word = bin_data_t'($random(seed));
         bus_write(ram_addr(ch, int'(rand_bin)), bus_word_t'(rand_word));
         check_bin_ram($sformatf("random word ch%0d", ch), ch, int'(rand_bin), rand_word);
      end

      drain = 0;
      while (checks.size() > 0) begin
         drain++;
         if (drain > DRAIN_MAX)
            abort_run("Result queue was not emptied by the comparing process");
         @(negedge clk);
      end
      $display("Regression passed");
      $finish;
   end

endmodule

// File: compile.f
src/cnt_pkg.sv
src/cnt_cfg_if.sv
src/interval_timer.sv
src/pulse_counter.sv
src/bin_memory.sv
src/count_fsm.sv
src/bus_regs.sv
src/counter_top.sv
verif/counter_tb_sva.sv
verif/counter_tb.sv

// File: Makefile
# Verilator build and run for the pulse counter testbench

VERILATOR ?= verilator
TOP       ?= counter_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
